//--- gat_attn.f
+incdir+include
hw/gat_pkg.sv
hw/dmvm_if.sv
hw/gat_wb_regs.sv
hw/wh_mem.sv
hw/dmvm_core.sv
hw/gat_attn_top.sv
dv/gat_attn_chk.sv
dv/gat_attn_tb.sv

//--- Makefile
# Verilator build for the gat_attn testbench
# override any variable on the command line, e.g. make run BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= gat_attn_tb
FILELIST  ?= gat_attn.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# a failing run ends in $fatal, so the exit status carries the result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

//--- dv/gat_attn_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "gat_params.svh"

module gat_attn_tb;
  import gat_pkg::*;

  localparam int          CLK_PERIOD   = 40;
  localparam int          DRIVE_DELAY  = 2;
  localparam logic [31:0] SEED         = 32'h14f7_d322;
  localparam int          MIN_SG       = 12;
  localparam int          MAX_SG       = 40;
  localparam int          ACK_LIMIT    = 16;
  localparam int          RUN_CYCLES   = 5 * `GAT_MAX_NODES + 2;
  localparam int          POLL_LIMIT   = RUN_CYCLES / 3 + 6;
  // longest run plus about 24 bus accesses of 3 cycles each
  localparam int          SG_CYCLES    = (5 * `GAT_MAX_NODES + 20) + 3 * 24;
  localparam int          SETUP_CYCLES = 3 * (2 * `GAT_WH_DEPTH + 2 * `GAT_MAX_NODES) + 10;
  localparam int          TIMEOUT_CYCLES = MAX_SG * SG_CYCLES + SETUP_CYCLES + 500;

  logic                   clk;
  logic                   rst_n;
  logic                   wb_cyc;
  logic                   wb_stb;
  logic                   wb_we;
  logic [`GAT_WB_AW-1:0]  wb_adr;
  logic [`GAT_WB_DW-1:0]  wb_dat_w;
  logic [3:0]             wb_sel;
  wire  [`GAT_WB_DW-1:0]  wb_dat_r;
  wire                    wb_ack;

  // reference model state
  int     feat_m [`GAT_WH_DEPTH][`GAT_HALF_A];
  bit     flag_m [`GAT_WH_DEPTH];
  int     cnt_m  [`GAT_WH_DEPTH];
  int     a_src_m [`GAT_HALF_A];
  int     a_nbr_m [`GAT_HALF_A];
  data_t  coef_m [`GAT_MAX_NODES];
  int     ptr_m;
  bit     wrapped;

  gat_attn_top UUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_w),
    .wb_sel_i (wb_sel),
    .wb_dat_o (wb_dat_r),
    .wb_ack_o (wb_ack)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "stopping on the first error");
  endtask

  task automatic compare_word(input string name, input logic [`GAT_WB_DW-1:0] got,
                              input logic [`GAT_WB_DW-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("ERROR at %0t: %s got 0x%08h expected 0x%08h",
                         $time, name, got, exp));
    end
  endtask

  task automatic compare_coef(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      fail_run($sformatf("ERROR at %0t: %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic compare_status(input string name, input logic [`GAT_NODE_W-1:0] got,
                                input logic [`GAT_NODE_W-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("ERROR at %0t: %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  // one classic cycle with ack sampled at the falling edge
  task automatic wb_access(input logic we, input logic [`GAT_WB_AW-1:0] adr,
                           input logic [`GAT_WB_DW-1:0] wdata,
                           output logic [`GAT_WB_DW-1:0] rdata);
    int waited;
    waited = 0;
    @(posedge clk);
    #DRIVE_DELAY;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    wb_sel   = 4'hF;
    @(negedge clk);
    while (!wb_ack) begin
      waited++;
      if (waited > ACK_LIMIT) begin
        fail_run($sformatf("no Wishbone ack for address 0x%03h within %0d cycles",
                           adr, ACK_LIMIT));
      end
      @(negedge clk);
    end
    rdata = wb_dat_r;
    @(posedge clk);
    #DRIVE_DELAY;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input logic [`GAT_WB_AW-1:0] adr, input logic [`GAT_WB_DW-1:0] data);
    logic [`GAT_WB_DW-1:0] unused;
    wb_access(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input logic [`GAT_WB_AW-1:0] adr, output logic [`GAT_WB_DW-1:0] data);
    wb_access(1'b0, adr, '0, data);
  endtask

  // feature 0 goes in the top byte and the odd word carries flag and count
  task automatic write_random_row(input int r, input int min_cnt);
    logic [31:0] feat_word;
    logic [31:0] rnd;
    int          span;
    feat_word = $urandom;
    rnd       = $urandom;
    span      = `GAT_MAX_NODES - min_cnt + 1;
    for (int i = 0; i < `GAT_HALF_A; i++) begin
      feat_m[r][i] = int'($signed(feat_word[31-8*i -: 8]));
    end
    flag_m[r] = rnd[0];
    cnt_m[r]  = min_cnt + int'(rnd[15:8]) % span;
    wb_write(`REG_WH + 12'(8 * r), feat_word);
    wb_write(`REG_WH + 12'(8 * r + 4), {27'b0, `GAT_NODE_W'(cnt_m[r]), flag_m[r]});
  endtask

  task automatic write_a_vectors();
    logic [31:0] src_word;
    logic [31:0] nbr_word;
    logic [31:0] rnd;
    logic [31:0] rd;
    src_word = $urandom;
    nbr_word = $urandom;
    rnd      = $urandom;
    for (int i = 0; i < `GAT_HALF_A; i++) begin
      a_src_m[i] = int'($signed(src_word[8*i +: 8]));
      a_nbr_m[i] = int'($signed(nbr_word[8*i +: 8]));
    end
    wb_write(`REG_A_SRC, src_word);
    wb_write(`REG_A_NBR, nbr_word);
    wb_read(`REG_A_SRC, rd);
    compare_word("a_src readback", rd, src_word);
    wb_read(`REG_A_NBR, rd);
    compare_word("a_nbr readback", rd, nbr_word);
    // addresses from 0x200 upward decode to nothing
    wb_read(12'h200 | {2'b00, rnd[9:2], 2'b00}, rd);
    compare_word("unmapped read", rd, 32'h0);
  endtask

  // coef k is (score0 + scorek) >> shift and zero when negative or k >= count
  task automatic predict_coefs(output int n);
    int score [`GAT_MAX_NODES];
    int r;
    int sum;
    n = cnt_m[ptr_m];
    for (int j = 0; j < n; j++) begin
      r        = (ptr_m + j) % `GAT_WH_DEPTH;
      score[j] = 0;
      for (int i = 0; i < `GAT_HALF_A; i++) begin
        score[j] += feat_m[r][i] * (flag_m[r] ? a_src_m[i] : a_nbr_m[i]);
      end
    end
    for (int k = 0; k < `GAT_MAX_NODES; k++) begin
      coef_m[k] = '0;
      if (k < n) begin
        sum = score[0] + score[k];
        if (sum >= 0) coef_m[k] = data_t'(sum >>> `GAT_ACT_SHIFT);
      end
    end
  endtask

  task automatic check_coefs();
    logic [31:0] rd;
    for (int k = 0; k < `GAT_MAX_NODES; k++) begin
      wb_read(`REG_COEF + 12'(4 * k), rd);
      compare_word($sformatf("coef[%0d] upper bits", k), rd & 32'hFFFF_FF00, 32'h0);
      compare_coef($sformatf("coef[%0d]", k), data_t'(rd[7:0]), coef_m[k]);
    end
  endtask

  task automatic run_subgraph(input bit double_start);
    logic [31:0] rd;
    int          n;
    int          polls;
    write_a_vectors();
    // a second start needs a run of at least two rows to land while busy
    write_random_row(ptr_m, double_start ? 2 : 1);
    predict_coefs(n);
    wb_write(`REG_CTRL, 32'h1);
    wb_read(`REG_STATUS, rd);
    compare_word("status busy after start", rd & 32'h3, 32'h1);
    if (double_start) wb_write(`REG_CTRL, 32'h1);
    polls = 0;
    rd    = '0;
    while (!rd[1]) begin
      if (polls > POLL_LIMIT) begin
        fail_run($sformatf("core gave no done within %0d status polls", POLL_LIMIT));
      end
      wb_read(`REG_STATUS, rd);
      polls++;
    end
    compare_word("status busy after done", rd & 32'h1, 32'h0);
    compare_status("status num_nodes", rd[7:4], `GAT_NODE_W'(n));
    check_coefs();
    if (ptr_m + n >= `GAT_WH_DEPTH) wrapped = 1'b1;
    ptr_m = (ptr_m + n) % `GAT_WH_DEPTH;
  endtask

  initial begin
    logic [31:0] rd;
    int          sg;
    clk         = 1'b0;
    rst_n       = 1'b0;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = '0;
    wb_dat_w    = '0;
    wb_sel      = '0;
    ptr_m       = 0;
    wrapped     = 1'b0;
    void'($urandom(SEED));
    repeat (3) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;

    // state straight out of reset
    wb_read(`REG_STATUS, rd);
    compare_word("status after reset", rd, 32'h0);
    for (int k = 0; k < `GAT_MAX_NODES; k++) coef_m[k] = '0;
    check_coefs();

    for (int r = 0; r < `GAT_WH_DEPTH; r++) write_random_row(r, 1);

    sg = 0;
    while (sg < MIN_SG || (!wrapped && sg < MAX_SG)) begin
      run_subgraph(sg % 4 == 1);
      sg++;
    end

    if (!wrapped) begin
      fail_run("row pointer never wrapped past the last WH row");
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    fail_run($sformatf("watchdog expired after %0d cycles", TIMEOUT_CYCLES));
  end

endmodule

`default_nettype wire

//--- dv/gat_attn_chk.sv
`timescale 1ns/1ps
`default_nettype none

module gat_attn_chk (
  input wire clk,
  input wire rst_n,
  input wire cyc_i,
  input wire stb_i,
  input wire ack_i,
  input wire busy_i,
  input wire done_i
);

  // ack is a single-cycle pulse
  ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) ack_i |=> !ack_i)
    else $error("wishbone ack held for more than one cycle");

  // no ack outside an active request
  ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n) ack_i |-> (cyc_i && stb_i))
    else $error("wishbone ack given without cyc and stb");

  // the core only leaves busy through its done pulse
  busy_until_done: assert property (@(posedge clk) disable iff (!rst_n)
    (busy_i && !done_i) |=> busy_i)
    else $error("core busy dropped without a done pulse");

  // done only comes out of a core that was already running
  done_after_busy: assert property (@(posedge clk) disable iff (!rst_n)
    done_i |-> $past(busy_i))
    else $error("core done pulse while idle");

endmodule

bind gat_attn_top gat_attn_chk u_chk (
  .clk    (clk),
  .rst_n  (rst_n),
  .cyc_i  (wb_cyc_i),
  .stb_i  (wb_stb_i),
  .ack_i  (wb_ack_o),
  .busy_i (u_dmvm_if.busy),
  .done_i (u_dmvm_if.done)
);

`default_nettype wire

//--- hw/gat_attn_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "gat_params.svh"

module gat_attn_top (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     wb_cyc_i,
  input  wire                     wb_stb_i,
  input  wire                     wb_we_i,
  input  wire  [`GAT_WB_AW-1:0]   wb_adr_i,
  input  wire  [`GAT_WB_DW-1:0]   wb_dat_i,
  input  wire  [3:0]              wb_sel_i,
  output wire  [`GAT_WB_DW-1:0]   wb_dat_o,
  output wire                     wb_ack_o
);
  import gat_pkg::*;

  // WH write path from the register block
  logic                   wh_we;
  logic [`GAT_WH_AW-1:0]  wh_waddr;
  logic                   wh_hi;
  logic [`GAT_WB_DW-1:0]  wh_wdata;
  // core read path
  logic [`GAT_WH_AW-1:0]  rd_addr;
  wh_row_t                rd_row;

  dmvm_if u_dmvm_if ();

  gat_wb_regs u_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_we_i    (wb_we_i),
    .wb_adr_i   (wb_adr_i),
    .wb_dat_i   (wb_dat_i),
    .wb_sel_i   (wb_sel_i),
    .wb_dat_o   (wb_dat_o),
    .wb_ack_o   (wb_ack_o),
    .bus        (u_dmvm_if.ctrl),
    .wh_we_o    (wh_we),
    .wh_waddr_o (wh_waddr),
    .wh_hi_o    (wh_hi),
    .wh_wdata_o (wh_wdata)
  );

  wh_mem u_wh_mem (
    .clk        (clk),
    .rst_n      (rst_n),
    .wh_we_i    (wh_we),
    .wh_waddr_i (wh_waddr),
    .wh_hi_i    (wh_hi),
    .wh_wdata_i (wh_wdata),
    .rd_addr_i  (rd_addr),
    .rd_row_o   (rd_row)
  );

  dmvm_core u_core (
    .clk       (clk),
    .rst_n     (rst_n),
    .bus       (u_dmvm_if.core),
    .rd_addr_o (rd_addr),
    .rd_row_i  (rd_row)
  );

endmodule

`default_nettype wire

//--- hw/dmvm_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "gat_params.svh"

module dmvm_core (
  input  wire                     clk,
  input  wire                     rst_n,
  dmvm_if.core                    bus,
  output logic [`GAT_WH_AW-1:0]   rd_addr_o,
  input  wire gat_pkg::wh_row_t   rd_row_i
);
  import gat_pkg::*;

  localparam int IdxW = $clog2(`GAT_MAX_NODES);

  dmvm_state_e             state_q;
  logic                    red_stage_q;
  logic [`GAT_WH_AW-1:0]   ptr_q;
  logic [IdxW-1:0]         node_q;
  logic [`GAT_NODE_W-1:0]  cnt_q;
  logic                    last_node;
  feat_vec_t               a_sel;
  acc_t                    prod_q  [`GAT_HALF_A];
  acc_t                    score_q [`GAT_MAX_NODES];
  acc_t                    act_sum [`GAT_MAX_NODES];
  coef_vec_t               coef_q;
  coef_vec_t               coef_d;

  // source rows use the first half of a
  assign a_sel = rd_row_i.src_flag ? bus.a_src : bus.a_nbr;

  // stop at the count, or at the last score slot
  assign last_node = (`GAT_NODE_W'(node_q) + 1'b1 >= cnt_q) ||
                     (node_q == IdxW'(`GAT_MAX_NODES - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= IDLE;
      red_stage_q <= 1'b0;
      ptr_q       <= '0;
      node_q      <= '0;
      cnt_q       <= '0;
      coef_q      <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (bus.start) begin
            node_q  <= '0;
            state_q <= FETCH;
          end
        end
        FETCH: state_q <= MUL;
        MUL: begin
          red_stage_q <= 1'b0;
          // count comes from the first row only
          if (node_q == '0) cnt_q <= rd_row_i.num_nodes;
          state_q <= RED;
        end
        RED: begin
          if (red_stage_q) begin
            state_q <= ACC;
          end else begin
            red_stage_q <= 1'b1;
          end
        end
        ACC: begin
          ptr_q <= (ptr_q == `GAT_WH_AW'(`GAT_WH_DEPTH - 1)) ? '0 : ptr_q + 1'b1;
          if (last_node) begin
            state_q <= ACT;
          end else begin
            node_q  <= node_q + 1'b1;
            state_q <= FETCH;
          end
        end
        ACT: begin
          coef_q  <= coef_d;
          state_q <= DONE;
        end
        DONE: state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // multiply, two-level adder tree, score store
  always_ff @(posedge clk) begin
    case (state_q)
      MUL: begin
        for (int i = 0; i < `GAT_HALF_A; i++) begin
          prod_q[i] <= $signed(rd_row_i.feat[i]) * $signed(a_sel[i]);
        end
      end
      RED: begin
        if (!red_stage_q) begin
          prod_q[0] <= prod_q[0] + prod_q[1];
          prod_q[1] <= prod_q[2] + prod_q[3];
        end else begin
          prod_q[0] <= prod_q[0] + prod_q[1];
        end
      end
      ACC: score_q[node_q] <= prod_q[0];
      default: ;
    endcase
  end

  // activation: clamp negative sums, keep bits above the shift
  always_comb begin
    for (int k = 0; k < `GAT_MAX_NODES; k++) begin
      act_sum[k] = score_q[0] + score_q[k];
      if (k >= int'(cnt_q) || act_sum[k] < 0) begin
        coef_d[k] = '0;
      end else begin
        coef_d[k] = data_t'(act_sum[k] >>> `GAT_ACT_SHIFT);
      end
    end
  end

  assign rd_addr_o     = ptr_q;
  assign bus.busy      = (state_q != IDLE);
  assign bus.done      = (state_q == DONE);
  assign bus.coef      = coef_q;
  assign bus.num_nodes = cnt_q;

endmodule

`default_nettype wire

//--- hw/wh_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "gat_params.svh"

module wh_mem (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     wh_we_i,
  input  wire  [`GAT_WH_AW-1:0]   wh_waddr_i,
  input  wire                     wh_hi_i,
  input  wire  [`GAT_WB_DW-1:0]   wh_wdata_i,
  input  wire  [`GAT_WH_AW-1:0]   rd_addr_i,
  output gat_pkg::wh_row_t        rd_row_o
);
  import gat_pkg::*;

  feat_vec_t               feat_mem [`GAT_WH_DEPTH];
  // flag in bit 0, node count above it
  logic [`GAT_NODE_W:0]    meta_mem [`GAT_WH_DEPTH];
  feat_vec_t               wr_feat;

  // feature 0 comes from the top byte of the word
  always_comb begin
    for (int i = 0; i < `GAT_HALF_A; i++) begin
      wr_feat[i] = wh_wdata_i[`GAT_WB_DW-1-8*i -: 8];
    end
  end

  always_ff @(posedge clk) begin
    if (wh_we_i) begin
      if (wh_hi_i) begin
        meta_mem[wh_waddr_i] <= wh_wdata_i[`GAT_NODE_W:0];
      end else begin
        feat_mem[wh_waddr_i] <= wr_feat;
      end
    end
  end

  // registered read, one cycle behind the address
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_row_o <= '0;
    end else begin
      rd_row_o.feat      <= feat_mem[rd_addr_i];
      rd_row_o.src_flag  <= meta_mem[rd_addr_i][0];
      rd_row_o.num_nodes <= meta_mem[rd_addr_i][`GAT_NODE_W:1];
    end
  end

endmodule

`default_nettype wire

//--- hw/gat_wb_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "gat_params.svh"

module gat_wb_regs (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     wb_cyc_i,
  input  wire                     wb_stb_i,
  input  wire                     wb_we_i,
  input  wire  [`GAT_WB_AW-1:0]   wb_adr_i,
  input  wire  [`GAT_WB_DW-1:0]   wb_dat_i,
  input  wire  [3:0]              wb_sel_i,
  output logic [`GAT_WB_DW-1:0]   wb_dat_o,
  output logic                    wb_ack_o,
  dmvm_if.ctrl                    bus,
  output logic                    wh_we_o,
  output logic [`GAT_WH_AW-1:0]   wh_waddr_o,
  output logic                    wh_hi_o,
  output logic [`GAT_WB_DW-1:0]   wh_wdata_o
);
  import gat_pkg::*;

  localparam int CoefIdxW = $clog2(`GAT_MAX_NODES);

  logic                   ack_q;
  logic                   wr_en;
  logic                   done_q;
  logic                   coef_hit;
  logic                   wh_hit;
  logic [`GAT_WB_AW-1:0]  coef_off;
  logic [`GAT_WB_AW-1:0]  wh_off;
  feat_vec_t              a_src_q;
  feat_vec_t              a_nbr_q;

  // single-cycle ack, dropped for one cycle so a held request acks once
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= wb_cyc_i & wb_stb_i & ~ack_q;
    end
  end

  assign wb_ack_o = ack_q;
  // any lane selected counts as a full word write
  assign wr_en    = ack_q & wb_we_i & (|wb_sel_i);

  // address windows
  assign coef_off = wb_adr_i - `REG_COEF;
  assign wh_off   = wb_adr_i - `REG_WH;
  assign coef_hit = (wb_adr_i >= `REG_COEF) && (coef_off < `GAT_MAX_NODES * 4);
  assign wh_hit   = (wb_adr_i >= `REG_WH) && (wh_off < `GAT_WH_DEPTH * 8);

  // a vectors, byte 0 is element 0
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_src_q <= '0;
      a_nbr_q <= '0;
    end else if (wr_en) begin
      for (int i = 0; i < `GAT_HALF_A; i++) begin
        if (wb_adr_i == `REG_A_SRC) a_src_q[i] <= wb_dat_i[8*i +: 8];
        if (wb_adr_i == `REG_A_NBR) a_nbr_q[i] <= wb_dat_i[8*i +: 8];
      end
    end
  end

  assign bus.a_src = a_src_q;
  assign bus.a_nbr = a_nbr_q;

  // start lands in the ack cycle, dropped while the core runs
  assign bus.start = wr_en && (wb_adr_i == `REG_CTRL) && wb_dat_i[0] && !bus.busy;

  // sticky done
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done_q <= 1'b0;
    end else if (bus.start) begin
      done_q <= 1'b0;
    end else if (bus.done) begin
      done_q <= 1'b1;
    end
  end

  // WH writes pass straight through to the row memory
  assign wh_we_o    = wr_en & wh_hit;
  assign wh_waddr_o = wh_off[`GAT_WH_AW+2:3];
  assign wh_hi_o    = wh_off[2];
  assign wh_wdata_o = wb_dat_i;

  // read mux, unmapped reads give 0
  always_comb begin
    wb_dat_o = '0;
    if (coef_hit) begin
      wb_dat_o[7:0] = bus.coef[coef_off[CoefIdxW+1:2]];
    end else begin
      case (wb_adr_i)
        `REG_STATUS: begin
          wb_dat_o[0]   = bus.busy;
          wb_dat_o[1]   = done_q;
          wb_dat_o[7:4] = bus.num_nodes;
        end
        `REG_A_SRC: begin
          for (int i = 0; i < `GAT_HALF_A; i++) wb_dat_o[8*i +: 8] = a_src_q[i];
        end
        `REG_A_NBR: begin
          for (int i = 0; i < `GAT_HALF_A; i++) wb_dat_o[8*i +: 8] = a_nbr_q[i];
        end
        default: wb_dat_o = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/dmvm_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "gat_params.svh"

interface dmvm_if;
  import gat_pkg::*;

  // register block to core
  logic       start;
  feat_vec_t  a_src;
  feat_vec_t  a_nbr;

  // core to register block
  logic                    busy;
  logic                    done;
  coef_vec_t               coef;
  logic [`GAT_NODE_W-1:0]  num_nodes;

  modport ctrl (output start, a_src, a_nbr, input busy, done, coef, num_nodes);
  modport core (input start, a_src, a_nbr, output busy, done, coef, num_nodes);

endinterface

`default_nettype wire

//--- hw/gat_pkg.sv
`default_nettype none

`include "gat_params.svh"

package gat_pkg;

  typedef logic signed [`GAT_DATA_W-1:0] data_t;
  typedef logic signed [`GAT_ACC_W-1:0]  acc_t;

  // element 0 sits in the low slice
  typedef data_t [`GAT_HALF_A-1:0] feat_vec_t;

  typedef struct packed {
    feat_vec_t               feat;
    logic                    src_flag;
    logic [`GAT_NODE_W-1:0]  num_nodes;
  } wh_row_t;

  typedef data_t [`GAT_MAX_NODES-1:0] coef_vec_t;

  // one pass per row is FETCH, MUL, RED, RED, ACC
  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    MUL,
    RED,
    ACC,
    ACT,
    DONE
  } dmvm_state_e;

endpackage

`default_nettype wire

//--- include/gat_params.svh
`ifndef GAT_PARAMS_SVH
`define GAT_PARAMS_SVH

// datapath widths and sizes
`define GAT_DATA_W     8
`define GAT_HALF_A     4
`define GAT_ACC_W      20
`define GAT_MAX_NODES  8
`define GAT_WH_DEPTH   32
`define GAT_WH_AW      5
`define GAT_NODE_W     4
`define GAT_ACT_SHIFT  12

// wishbone bus widths
`define GAT_WB_AW      12
`define GAT_WB_DW      32

// register map, byte offsets
`define REG_CTRL       12'h000
`define REG_STATUS     12'h004
`define REG_A_SRC      12'h008
`define REG_A_NBR      12'h00C
`define REG_COEF       12'h080
`define REG_WH         12'h100

`endif
